/* Makefile */
# Verilator build and run of the data cache testbench
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_TEXT := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  logic                                        p_strobe_i,
    input  logic                                        p_rw_i,
    input  logic [dcache_pkg::XLEN-1:0]                 p_addr_i,
    input  logic                                        hit_i,
    input  logic [dcache_pkg::WAY_BITS-1:0]             hit_way_i,
    input  logic [dcache_pkg::N_WAYS-1:0][dcache_pkg::TAG_BITS-1:0] way_tag_i,
    input  logic [dcache_pkg::N_WAYS-1:0]               way_dirty_i,
    input  logic [dcache_pkg::N_WAYS-1:0][dcache_pkg::LINE_W-1:0]   way_line_i,
    input  logic [dcache_pkg::WAY_BITS-1:0]             victim_way_i,
    input  logic [dcache_pkg::XLEN-1:0]                 rd_word_i,
    input  logic [dcache_pkg::LINE_W-1:0]               merged_line_i,
    input  logic [dcache_pkg::LINE_W-1:0]               m_data_i,
    input  logic                                        m_ready_i,
    output dcache_pkg::dcache_addr_u                    req_addr_o,
    output logic [dcache_pkg::LINE_W-1:0]               sel_line_o,
    output logic [dcache_pkg::LINE_W-1:0]               wr_line_o,
    output logic [dcache_pkg::N_WAYS-1:0]               wr_way_o,
    output logic [dcache_pkg::N_WAYS-1:0]               valid_we_o,
    output logic [dcache_pkg::N_WAYS-1:0]               dirty_we_o,
    output logic                                        dirty_val_o,
    output logic                                        init_o,
    output logic [dcache_pkg::SET_BITS-1:0]             init_set_o,
    output logic                                        touch_o,
    output logic [dcache_pkg::WAY_BITS-1:0]             touch_way_o,
    output logic [dcache_pkg::XLEN-1:0]                 p_data_o,
    output logic                                        p_ready_o,
    output logic                                        m_strobe_o,
    output logic                                        m_rw_o,
    output logic [dcache_pkg::XLEN-1:0]                 m_addr_o,
    output logic [dcache_pkg::LINE_W-1:0]               m_data_o
);
    import dcache_pkg::*;

    ctrl_state_e          state_q, state_d;
    dcache_addr_u         addr_q;           // Request held for the whole miss
    logic                 rw_q;
    logic [WAY_BITS-1:0]  victim_q;         // Way picked at lookup
    logic [LINE_W-1:0]    refill_q;         // Line returned by memory
    logic [SET_BITS-1:0]  init_cnt_q;
    logic                 mem_req, mem_req_q;
    logic [N_WAYS-1:0]    hit_oh, victim_oh;

    assign hit_oh    = N_WAYS'(1) << hit_way_i;
    assign victim_oh = N_WAYS'(1) << victim_q;

    // Storage sees the incoming address at the strobe so that
    // its synchronous read is ready during Lookup
    always_comb
    begin
        if (state_q == Idle && p_strobe_i)
            req_addr_o.raw = p_addr_i;
        else
            req_addr_o = addr_q;
    end

    // ======================================================================
    // State machine
    // ======================================================================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            Init:          if (init_cnt_q == SET_BITS'(N_SETS - 1)) state_d = Idle;
            Idle:          if (p_strobe_i) state_d = Lookup;
            Lookup:
            begin
                if (hit_i)
                    state_d = Idle;
                else if (way_dirty_i[victim_way_i])  // Dirty implies valid
                    state_d = WriteBack;
                else
                    state_d = Refill;
            end
            WriteBack:     if (m_ready_i) state_d = WriteBackDone;
            WriteBackDone: state_d = Refill;
            Refill:        if (m_ready_i) state_d = RefillDone;
            RefillDone:    state_d = Idle;
            default:       state_d = Idle;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q    <= Init;
            init_cnt_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == Init)
                init_cnt_q <= init_cnt_q + 1'b1;    // One set per cycle
        end
    end

    assign init_o     = (state_q == Init);
    assign init_set_o = init_cnt_q;

    // Request and miss payload
    always_ff @(posedge clk_i)
    begin
        if (state_q == Idle && p_strobe_i)
        begin
            addr_q.raw <= p_addr_i;
            rw_q       <= p_rw_i;
        end
        if (state_q == Lookup)
            victim_q <= victim_way_i;               // Replacement bits as of now
        if (state_q == Refill && m_ready_i)
            refill_q <= m_data_i;
    end

    // ======================================================================
    // Storage writes
    // ======================================================================
    always_comb
    begin
        sel_line_o  = way_line_i[hit_way_i];
        wr_line_o   = merged_line_i;
        wr_way_o    = '0;
        valid_we_o  = '0;
        dirty_we_o  = '0;
        dirty_val_o = 1'b0;
        case (state_q)
            Init:
            begin
                valid_we_o = '1;                    // Cleared in every way
                dirty_we_o = '1;
            end
            Lookup:
            begin
                if (hit_i && rw_q)                  // Write hit marks the line dirty
                begin
                    wr_way_o    = hit_oh;
                    dirty_we_o  = hit_oh;
                    dirty_val_o = 1'b1;
                end
            end
            RefillDone:
            begin
                sel_line_o  = refill_q;
                wr_line_o   = rw_q ? merged_line_i : refill_q;
                wr_way_o    = victim_oh;
                valid_we_o  = victim_oh;
                dirty_we_o  = victim_oh;
                dirty_val_o = rw_q;                 // Write miss installs dirty
            end
            default: ;
        endcase
    end

    // Processor answer
    assign p_ready_o   = (state_q == Lookup && hit_i) || (state_q == RefillDone);
    assign p_data_o    = (p_ready_o && !rw_q) ? rd_word_i : '0;
    assign touch_o     = p_ready_o;
    assign touch_way_o = (state_q == Lookup) ? hit_way_i : victim_q;

    // ======================================================================
    // Memory transfer with one strobe per state visit
    // ======================================================================
    assign mem_req = (state_q == WriteBack || state_q == Refill) && !m_ready_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mem_req_q  <= 1'b0;
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
        end
        else
        begin
            mem_req_q  <= mem_req;
            m_strobe_o <= mem_req && !mem_req_q;    // Rising edge only
            m_rw_o     <= (state_q == WriteBack);
        end
    end

    // Held while the state waits for m_ready_i
    always_ff @(posedge clk_i)
    begin
        if (state_q == WriteBack)
        begin
            m_addr_o <= {way_tag_i[victim_q], addr_q.f.set, (WORD_BITS + BYTE_BITS)'(0)};
            m_data_o <= way_line_i[victim_q];
        end
        else if (state_q == Refill)
            m_addr_o <= {addr_q.f.tag, addr_q.f.set, (WORD_BITS + BYTE_BITS)'(0)};
    end

    // Strobe only inside a transfer state and never twice in a row
    a_strobe_single : assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_o |-> (state_q inside {WriteBack, Refill}) && !$past(m_strobe_o));
    // Answer follows an accepted strobe or the refill data
    a_ready_state : assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_o |-> (state_q == Lookup && $past(p_strobe_i)) ||
                      (state_q == RefillDone && $past(m_ready_i)));

endmodule

/* hw/dcache_pkg.sv */
package dcache_pkg;

    // ======================================================================
    // Cache geometry
    // ======================================================================
    localparam int XLEN      = 32;              // Processor word
    localparam int LINE_W    = 128;             // One cache line
    localparam int N_WAYS    = 4;
    localparam int N_SETS    = 16;
    localparam int N_WORDS   = LINE_W / XLEN;   // Words per line

    localparam int WAY_BITS  = $clog2(N_WAYS);
    localparam int SET_BITS  = $clog2(N_SETS);
    localparam int WORD_BITS = $clog2(N_WORDS);
    localparam int BYTE_BITS = $clog2(XLEN / 8);
    localparam int TAG_BITS  = XLEN - SET_BITS - WORD_BITS - BYTE_BITS;

    // ======================================================================
    // Address word seen raw or split into its cache fields
    // ======================================================================
    typedef union packed {
        logic [XLEN-1:0] raw;                   // Full byte address
        struct packed {
            logic [TAG_BITS-1:0]  tag;          // Compared against stored tags
            logic [SET_BITS-1:0]  set;          // Index into every way
            logic [WORD_BITS-1:0] word;         // Word inside the line
            logic [BYTE_BITS-1:0] byte_ofs;     // Byte inside the word
        } f;
    } dcache_addr_u;

    // Controller states
    typedef enum logic [2:0] {
        Init,                                   // Clearing valid and dirty bits
        Idle,
        Lookup,                                 // Tag compare and hit answer
        WriteBack,                              // Dirty victim out to memory
        WriteBackDone,
        Refill,                                 // Line fetch from memory
        RefillDone                              // Line install and answer
    } ctrl_state_e;

endpackage

/* hw/dcache_top.sv */
`timescale 1ns/1ps

// Processor keeps p_data_i and p_byte_enable_i steady until p_ready_o,
// the same way it keeps p_addr_i, so the merge reads them directly
module dcache_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Processor side
    input  logic                            p_strobe_i,
    input  logic                            p_rw_i,          // 1 = write
    input  logic [dcache_pkg::XLEN/8-1:0]   p_byte_enable_i,
    input  logic [dcache_pkg::XLEN-1:0]     p_addr_i,
    input  logic [dcache_pkg::XLEN-1:0]     p_data_i,
    output logic [dcache_pkg::XLEN-1:0]     p_data_o,
    output logic                            p_ready_o,
    // Memory side
    output logic                            m_strobe_o,
    output logic                            m_rw_o,
    output logic [dcache_pkg::XLEN-1:0]     m_addr_o,
    input  logic [dcache_pkg::LINE_W-1:0]   m_data_i,
    output logic [dcache_pkg::LINE_W-1:0]   m_data_o,
    input  logic                            m_ready_i
);
    import dcache_pkg::*;

    dcache_addr_u                      req_addr;       // Storage index and tag
    logic                              hit;
    logic [WAY_BITS-1:0]               hit_way;
    logic [N_WAYS-1:0][TAG_BITS-1:0]   way_tag;
    logic [N_WAYS-1:0]                 way_dirty;
    logic [N_WAYS-1:0][LINE_W-1:0]     way_line;
    logic [WAY_BITS-1:0]               victim_way;
    logic [XLEN-1:0]                   rd_word;
    logic [LINE_W-1:0]                 sel_line, merged_line, wr_line;
    logic [N_WAYS-1:0]                 wr_way, valid_we, dirty_we;
    logic                              dirty_val;
    logic                              init;
    logic [SET_BITS-1:0]               init_set;
    logic                              touch;
    logic [WAY_BITS-1:0]               touch_way;

    dcache_ctrl u_ctrl (
        .clk_i, .rst_i,
        .p_strobe_i, .p_rw_i, .p_addr_i,
        .hit_i(hit), .hit_way_i(hit_way),
        .way_tag_i(way_tag), .way_dirty_i(way_dirty), .way_line_i(way_line),
        .victim_way_i(victim_way),
        .rd_word_i(rd_word), .merged_line_i(merged_line),
        .m_data_i, .m_ready_i,
        .req_addr_o(req_addr), .sel_line_o(sel_line), .wr_line_o(wr_line),
        .wr_way_o(wr_way), .valid_we_o(valid_we), .dirty_we_o(dirty_we),
        .dirty_val_o(dirty_val), .init_o(init), .init_set_o(init_set),
        .touch_o(touch), .touch_way_o(touch_way),
        .p_data_o, .p_ready_o,
        .m_strobe_o, .m_rw_o, .m_addr_o, .m_data_o
    );

    way_array u_ways (
        .clk_i,
        .req_addr_i(req_addr), .wr_line_i(wr_line), .wr_way_i(wr_way),
        .valid_we_i(valid_we), .dirty_we_i(dirty_we), .dirty_val_i(dirty_val),
        .init_i(init), .init_set_i(init_set),
        .hit_o(hit), .hit_way_o(hit_way),
        .way_tag_o(way_tag), .way_dirty_o(way_dirty), .way_line_o(way_line)
    );

    plru_replacer u_plru (
        .clk_i, .rst_i,
        .set_i(req_addr.f.set),
        .touch_i(touch), .touch_way_i(touch_way),
        .victim_way_o(victim_way)
    );

    word_merge u_merge (
        .line_i(sel_line), .word_sel_i(req_addr.f.word),
        .byte_en_i(p_byte_enable_i), .wdata_i(p_data_i),
        .word_o(rd_word), .line_o(merged_line)
    );

endmodule

/* hw/plru_replacer.sv */
`timescale 1ns/1ps

module plru_replacer (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [dcache_pkg::SET_BITS-1:0] set_i,
    input  logic                            touch_i,
    input  logic [dcache_pkg::WAY_BITS-1:0] touch_way_i,
    output logic [dcache_pkg::WAY_BITS-1:0] victim_way_o
);
    import dcache_pkg::*;

    // bit0 picks the pair, bit1 the way in 0/1, bit2 the way in 2/3
    logic [2:0] lru_q [N_SETS];
    logic [2:0] cur;

    assign cur = lru_q[set_i];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                lru_q[s] <= '0;
        end
        else if (touch_i)
        begin
            lru_q[set_i][0] <= !touch_way_i[1];         // Point away from used pair
            if (touch_way_i[1])
                lru_q[set_i][2] <= !touch_way_i[0];     // Way 2 sets, way 3 clears
            else
                lru_q[set_i][1] <= !touch_way_i[0];     // Way 0 sets, way 1 clears
        end
    end

    // Victim follows the tree
    assign victim_way_o = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

endmodule

/* hw/way_array.sv */
`timescale 1ns/1ps

module way_array (
    input  logic                                        clk_i,
    input  dcache_pkg::dcache_addr_u                    req_addr_i,
    input  logic [dcache_pkg::LINE_W-1:0]               wr_line_i,
    input  logic [dcache_pkg::N_WAYS-1:0]               wr_way_i,     // Tag and data write
    input  logic [dcache_pkg::N_WAYS-1:0]               valid_we_i,
    input  logic [dcache_pkg::N_WAYS-1:0]               dirty_we_i,
    input  logic                                        dirty_val_i,
    input  logic                                        init_i,
    input  logic [dcache_pkg::SET_BITS-1:0]             init_set_i,
    output logic                                        hit_o,
    output logic [dcache_pkg::WAY_BITS-1:0]             hit_way_o,
    output logic [dcache_pkg::N_WAYS-1:0][dcache_pkg::TAG_BITS-1:0] way_tag_o,
    output logic [dcache_pkg::N_WAYS-1:0]               way_dirty_o,
    output logic [dcache_pkg::N_WAYS-1:0][dcache_pkg::LINE_W-1:0]   way_line_o
);
    import dcache_pkg::*;

    logic [SET_BITS-1:0] rd_set_q;      // Registered read index
    logic [SET_BITS-1:0] wr_set;
    logic [N_WAYS-1:0]   way_valid;
    logic [N_WAYS-1:0]   way_hit;

    always_ff @(posedge clk_i)
        rd_set_q <= req_addr_i.f.set;

    // Sweep counter owns the index during init
    assign wr_set = init_i ? init_set_i : req_addr_i.f.set;

    // ======================================================================
    // Per-way storage
    // ======================================================================
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        logic [TAG_BITS-1:0] tag_mem   [N_SETS];
        logic [LINE_W-1:0]   data_mem  [N_SETS];
        logic                valid_mem [N_SETS];
        logic                dirty_mem [N_SETS];

        always_ff @(posedge clk_i)
        begin
            if (wr_way_i[w])
            begin
                tag_mem[wr_set]  <= req_addr_i.f.tag;
                data_mem[wr_set] <= wr_line_i;
            end
            if (valid_we_i[w])
                valid_mem[wr_set] <= !init_i;   // Set on refill, cleared on init
            if (dirty_we_i[w])
                dirty_mem[wr_set] <= dirty_val_i;
        end

        assign way_tag_o[w]   = tag_mem[rd_set_q];
        assign way_line_o[w]  = data_mem[rd_set_q];
        assign way_valid[w]   = valid_mem[rd_set_q];
        assign way_dirty_o[w] = dirty_mem[rd_set_q];
        assign way_hit[w]     = way_valid[w] && (way_tag_o[w] == req_addr_i.f.tag);
    end

    // Hit detection and way encode
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (way_hit[w])
                hit_way_o = WAY_BITS'(w);
        end
    end

    assign hit_o = |way_hit;

    // A refill never installs a tag that is already present in the set
    a_single_hit : assert property (@(posedge clk_i) disable iff (init_i)
        $onehot0(way_hit));

endmodule

/* hw/word_merge.sv */
`timescale 1ns/1ps

module word_merge (
    input  logic [dcache_pkg::LINE_W-1:0]    line_i,
    input  logic [dcache_pkg::WORD_BITS-1:0] word_sel_i,
    input  logic [dcache_pkg::XLEN/8-1:0]    byte_en_i,
    input  logic [dcache_pkg::XLEN-1:0]      wdata_i,
    output logic [dcache_pkg::XLEN-1:0]      word_o,
    output logic [dcache_pkg::LINE_W-1:0]    line_o
);
    import dcache_pkg::*;

    // Word 0 sits at the top of the line
    assign word_o = line_i[(N_WORDS - 1 - word_sel_i) * XLEN +: XLEN];

    // Enabled bytes of the addressed word take the write data
    always_comb
    begin
        line_o = line_i;
        for (int w = 0; w < N_WORDS; w++)
        begin
            if (word_sel_i == WORD_BITS'(w))
            begin
                for (int b = 0; b < XLEN / 8; b++)
                begin
                    if (byte_en_i[b])
                        line_o[(N_WORDS - 1 - w) * XLEN + 8 * b +: 8] = wdata_i[8 * b +: 8];
                end
            end
        end
    end

endmodule

/* verification/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int          CLK_HALF = 4;            // 8 ns clock
    localparam int          N_REQ    = 1000;         // Processor requests in the run
    localparam int          N_LINES  = 64;           // Address pool in lines
    localparam logic [31:0] SEED     = 32'h74197bdb;

    logic              clk, rst;
    logic              p_strobe, p_rw, p_ready;
    logic [XLEN/8-1:0] p_be;
    logic [XLEN-1:0]   p_addr, p_wdata, p_rdata, m_addr;
    logic              m_strobe, m_rw, m_ready, mem_fail;
    logic [LINE_W-1:0] m_wdata, m_rdata;

    // Reference model of the memory image and the cache directory
    logic [XLEN-1:0]     ref_mem [N_LINES][N_WORDS];
    logic [TAG_BITS-1:0] tag_m   [N_SETS][N_WAYS];
    logic                valid_m [N_SETS][N_WAYS];
    logic                dirty_m [N_SETS][N_WAYS];
    logic [2:0]          plru_m  [N_SETS];
    int                  hit_cnt, miss_cnt, wb_cnt;
    logic [3:0]          be_list [7] = '{4'b0001, 4'b0011, 4'b0010, 4'b0100,
                                         4'b1100, 4'b1000, 4'b1111};

    dcache_top DUT (
        .clk_i(clk), .rst_i(rst),
        .p_strobe_i(p_strobe), .p_rw_i(p_rw), .p_byte_enable_i(p_be),
        .p_addr_i(p_addr), .p_data_i(p_wdata), .p_data_o(p_rdata), .p_ready_o(p_ready),
        .m_strobe_o(m_strobe), .m_rw_o(m_rw), .m_addr_o(m_addr),
        .m_data_i(m_rdata), .m_data_o(m_wdata), .m_ready_i(m_ready)
    );

    mem_model u_mem (
        .clk_i(clk), .m_strobe_i(m_strobe), .m_rw_i(m_rw), .m_addr_i(m_addr),
        .m_data_i(m_wdata), .m_ready_o(m_ready), .m_data_o(m_rdata), .fail_o(mem_fail)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ======================================================================
    // Model helpers
    // ======================================================================
    // Upper half of the pool crowds sets 0 to 7 so that they see evictions
    function automatic logic [SET_BITS-1:0] set_of_line(input int idx);
        logic [5:0] i;
        i = 6'(idx);
        return i[5] ? {1'b0, i[2:0]} : i[3:0];
    endfunction

    function automatic logic [XLEN-1:0] addr_of_line(input int idx);
        return {TAG_BITS'(idx), set_of_line(idx), 4'h0};   // Tag equals line index
    endfunction

    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return {addr[7:0], addr[31:8]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic [LINE_W-1:0] pack_line(input int idx);
        return {ref_mem[idx][0], ref_mem[idx][1], ref_mem[idx][2], ref_mem[idx][3]};
    endfunction

    function automatic logic [WAY_BITS-1:0] pick_victim(input logic [2:0] bits);
        if (bits[0] == 1'b0)
            return {1'b0, bits[1]};                  // Way 0 or 1
        else
            return {1'b1, bits[2]};                  // Way 2 or 3
    endfunction

    function automatic logic [2:0] touch_bits(input logic [2:0] bits, input logic [1:0] w);
        logic [2:0] nb;
        nb    = bits;
        nb[0] = (w == 2'd0 || w == 2'd1);
        case (w)
            2'd0:    nb[1] = 1'b1;
            2'd1:    nb[1] = 1'b0;
            2'd2:    nb[2] = 1'b1;
            default: nb[2] = 1'b0;
        endcase
        return nb;
    endfunction

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    // One processor request from falling edge to falling edge
    task automatic run_access(input int idx, input int word, input logic rw,
                              input logic [3:0] be, input logic [XLEN-1:0] wdata);
        logic [SET_BITS-1:0] s;
        logic [TAG_BITS-1:0] t;
        logic [WAY_BITS-1:0] w;
        logic                resident, wb_due;
        logic [XLEN-1:0]     exp_word, wb_addr_exp;
        logic [LINE_W-1:0]   wb_data_exp;
        int                  lat, wb_seen;
        s           = set_of_line(idx);
        t           = TAG_BITS'(idx);
        exp_word    = rw ? '0 : ref_mem[idx][word];  // Write answers carry no data
        resident    = 1'b0;
        wb_due      = 1'b0;
        w           = '0;
        wb_addr_exp = '0;
        wb_data_exp = '0;
        for (int k = 0; k < N_WAYS; k++)
        begin
            if (valid_m[s][k] && tag_m[s][k] == t)
            begin
                resident = 1'b1;
                w        = WAY_BITS'(k);
            end
        end
        if (!resident)
        begin
            w      = pick_victim(plru_m[s]);
            wb_due = valid_m[s][w] && dirty_m[s][w];
            if (wb_due)
            begin
                wb_addr_exp = addr_of_line(int'(tag_m[s][w]));
                wb_data_exp = pack_line(int'(tag_m[s][w]));
            end
        end
        p_strobe = 1'b1;
        p_rw     = rw;
        p_be     = be;
        p_addr   = addr_of_line(idx) | XLEN'(word * 4);
        p_wdata  = wdata;
        @(negedge clk);
        p_strobe = 1'b0;
        lat      = 1;
        wb_seen  = 0;
        while (!p_ready)                             // Watchdog bounds this wait
        begin
            check_value("p_data_o", LINE_W'(p_rdata), LINE_W'(0));    // Zero until ready
            if (m_strobe && m_rw)
            begin
                wb_seen++;
                check_value("m_addr_o", LINE_W'(m_addr), LINE_W'(wb_addr_exp));
                check_value("m_data_o", m_wdata, wb_data_exp);
            end
            else if (m_strobe)
                check_value("m_addr_o", LINE_W'(m_addr), LINE_W'(addr_of_line(idx)));
            @(negedge clk);
            lat++;
        end
        if (resident)
            check_value("p_ready_o hit latency", LINE_W'(lat), LINE_W'(1));
        else
            check_value("p_ready_o miss latency above 1", LINE_W'(lat > 1), LINE_W'(1));
        check_value("p_data_o", LINE_W'(p_rdata), LINE_W'(exp_word));
        check_value("write-back count", LINE_W'(wb_seen), LINE_W'(wb_due));
        // Model update
        if (rw)
        begin
            for (int b = 0; b < XLEN / 8; b++)
                if (be[b])
                    ref_mem[idx][word][8 * b +: 8] = wdata[8 * b +: 8];
        end
        if (!resident)
        begin
            tag_m[s][w]   = t;
            valid_m[s][w] = 1'b1;
            dirty_m[s][w] = rw;
            miss_cnt++;
        end
        else
        begin
            dirty_m[s][w] = dirty_m[s][w] | rw;
            hit_cnt++;
        end
        wb_cnt    += wb_seen;
        plru_m[s]  = touch_bits(plru_m[s], w);
        @(posedge clk);                              // Inputs held through the storage write
        @(negedge clk);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial
    begin
        int         idx, word, req_cnt;
        logic [3:0] be;
        logic [XLEN-1:0] wdata;
        void'($urandom(SEED));
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_be     = '0;
        p_addr   = '0;
        p_wdata  = '0;
        rst      = 1'b1;
        hit_cnt  = 0;
        miss_cnt = 0;
        wb_cnt   = 0;
        for (int i = 0; i < N_LINES; i++)
            for (int k = 0; k < N_WORDS; k++)
                ref_mem[i][k] = fill_word(addr_of_line(i) + XLEN'(4 * k));
        for (int s = 0; s < N_SETS; s++)
        begin
            plru_m[s] = '0;
            for (int w = 0; w < N_WAYS; w++)
            begin
                tag_m[s][w]   = '0;
                valid_m[s][w] = 1'b0;
                dirty_m[s][w] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (N_SETS + 2)                          // Cache stays quiet through the init sweep
        begin
            @(negedge clk);
            check_value("m_strobe_o", LINE_W'(m_strobe), LINE_W'(0));
            check_value("p_ready_o", LINE_W'(p_ready), LINE_W'(0));
        end
        req_cnt = 0;
        while (req_cnt < N_REQ)
        begin
            idx  = $urandom_range(0, N_LINES - 1);
            word = $urandom_range(0, N_WORDS - 1);
            if ($urandom_range(0, 9) < 4 && req_cnt + 1 < N_REQ)
            begin
                be    = be_list[$urandom_range(0, 6)];
                wdata = $urandom;
                run_access(idx, word, 1'b1, be, wdata);
                run_access(idx, word, 1'b0, 4'b0000, '0);    // Read back merged bytes
                req_cnt += 2;
            end
            else
            begin
                run_access(idx, word, 1'b0, 4'b0000, '0);
                req_cnt++;
            end
        end
        if (hit_cnt == 0 || miss_cnt == 0 || wb_cnt == 0)
        begin
            $display("Stimulus never reached a hit, a miss and a write-back");
            $display("Test failed");
            $fatal(1, "Incomplete stimulus");
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

    initial
    begin
        wait (mem_fail === 1'b1);
        $display("Test failed");
        $fatal(1, "Memory interface violation");
    end

    // Watchdog
    initial
    begin
        ctrl_state_e st;
        repeat (N_REQ * 200) @(posedge clk);
        st = DUT.u_ctrl.state_q;
        $display("Watchdog expired after %0d cycles, controller in state %s",
                 N_REQ * 200, st.name());
        $display("Test failed");
        $fatal(1, "Timeout");
    end

endmodule

/* verification/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
    input  logic                          clk_i,
    input  logic                          m_strobe_i,
    input  logic                          m_rw_i,        // 1 = line write
    input  logic [dcache_pkg::XLEN-1:0]   m_addr_i,
    input  logic [dcache_pkg::LINE_W-1:0] m_data_i,
    output logic                          m_ready_o,
    output logic [dcache_pkg::LINE_W-1:0] m_data_o,
    output logic                          fail_o         // Interface rule broken
);
    import dcache_pkg::*;

    localparam int MAX_DELAY = 5;                      // Longest answer delay in cycles

    logic [LINE_W-1:0] store [logic [XLEN-1:0]];       // Only lines written back

    // Unwritten memory shows a pattern of the full word address
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return {addr[7:0], addr[31:8]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic [LINE_W-1:0] line_at(input logic [XLEN-1:0] addr);
        logic [LINE_W-1:0] line;
        if (store.exists(addr))
            return store[addr];
        for (int k = 0; k < N_WORDS; k++)
            line[(N_WORDS - 1 - k) * XLEN +: XLEN] = fill_word(addr + XLEN'(4 * k));
        return line;
    endfunction

    // ======================================================================
    // Request capture, hold check and answer
    // ======================================================================
    initial
    begin
        logic              req_rw;
        logic [XLEN-1:0]   req_addr;
        logic [LINE_W-1:0] req_data;
        int                delay;
        m_ready_o = 1'b0;
        m_data_o  = '0;
        fail_o    = 1'b0;
        forever
        begin
            @(negedge clk_i);
            m_ready_o = 1'b0;                          // Ready is a single pulse
            m_data_o  = '0;
            if (m_strobe_i)
            begin
                req_rw   = m_rw_i;
                req_addr = m_addr_i;
                req_data = m_data_i;
                if (req_addr[WORD_BITS+BYTE_BITS-1:0] != '0)
                begin
                    $display("Memory request address %h is not line aligned", req_addr);
                    fail_o = 1'b1;
                end
                delay = $urandom_range(1, MAX_DELAY);
                repeat (delay)
                begin
                    @(negedge clk_i);
                    if (m_rw_i !== req_rw || m_addr_i !== req_addr || m_data_i !== req_data)
                    begin
                        $display("Memory request changed before m_ready_i at %0t ns", $time);
                        fail_o = 1'b1;
                    end
                    if (m_strobe_i)
                    begin
                        $display("Second memory strobe before the answer at %0t ns", $time);
                        fail_o = 1'b1;
                    end
                end
                if (req_rw)
                    store[req_addr] = req_data;        // Write-back of a victim
                else
                    m_data_o = line_at(req_addr);      // Refill data with the ready pulse
                m_ready_o = 1'b1;
            end
        end
    end

endmodule

/* verilog.f */
hw/dcache_pkg.sv
hw/word_merge.sv
hw/plru_replacer.sv
hw/way_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/mem_model.sv
verification/dcache_tb.sv
